// ==== rtl/rv_pkg.sv ====
package rv_pkg;

    localparam int xlen      = 32;                          // data and address width
    localparam int reg_count = 32;                          // architectural registers x0..x31

    localparam logic [xlen-1:0] reset_vec   = '0;           // first fetch address
    localparam logic [xlen-1:0] instr_bytes = xlen'(4);     // fixed 32-bit instruction size

    // funct3 codes of the alu group, shared by the r and i forms
    localparam logic [2:0] f3_add = 3'b000;                 // add, sub, addi
    localparam logic [2:0] f3_slt = 3'b010;                 // slt, slti
    localparam logic [2:0] f3_or  = 3'b110;                 // or, ori
    localparam logic [2:0] f3_and = 3'b111;                 // and, andi

    typedef enum logic [6:0] {
        op_load   = 7'd3,                                   // lw
        op_imm    = 7'd19,                                  // addi, andi, ori, slti
        op_store  = 7'd35,                                  // sw
        op_r      = 7'd51,                                  // register-register alu
        op_branch = 7'd99,                                  // beq
        op_jal    = 7'd111                                  // jal
    } opcode_e;

    typedef enum logic [1:0] {
        imm_i = 2'd0,                                       // loads and alu immediates
        imm_s = 2'd1,                                       // stores
        imm_b = 2'd2,                                       // branches
        imm_j = 2'd3                                        // jal
    } imm_src_e;

    typedef enum logic [1:0] {
        res_alu = 2'd0,                                     // alu result to rd
        res_mem = 2'd1,                                     // load data to rd
        res_pc4 = 2'd2                                      // link address to rd
    } result_src_e;

    typedef enum logic [1:0] {
        aop_add   = 2'd0,                                   // address calculation
        aop_sub   = 2'd1,                                   // compare for beq
        aop_funct = 2'd2                                    // look at funct3 and funct7
    } alu_op_e;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sub = 3'b001,
        alu_and = 3'b010,
        alu_or  = 3'b011,
        alu_slt = 3'b101                                    // signed less-than
    } alu_ctrl_e;

    // one struct per encoding format, msb first, 32 bits each
    typedef struct packed {
        logic [6:0] funct7;                                 // bit 5 marks sub
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;                                   // imm[11:0]
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;                                 // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;                                 // imm[4:0]
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;                                 // sign bit
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm_20;                                 // sign bit
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        j_fmt_t j;
    } instr_t;                                              // one word, five views

    typedef struct packed {
        logic        pc_src;                                // take pc+imm
        result_src_e result_src;
        logic        mem_write;
        logic        alu_src;                               // immediate as operand b
        imm_src_e    imm_src;
        logic        reg_write;
        alu_op_e     alu_op;
    } ctrl_t;

    typedef struct packed {
        logic            we;
        logic [xlen-1:0] addr;                              // byte address, word aligned
        logic [xlen-1:0] wdata;
    } dmem_req_t;

    // control word of an unknown opcode, no state changes at all
    localparam ctrl_t ctrl_nop = '{
        pc_src:     1'b0,
        result_src: res_alu,
        mem_write:  1'b0,
        alu_src:    1'b0,
        imm_src:    imm_i,
        reg_write:  1'b0,
        alu_op:     aop_add
    };

endpackage

// ==== rtl/main_decoder.sv ====
module main_decoder import rv_pkg::*; (
    input  opcode_e opcode,                         // low 7 bits of the instruction
    input  logic    eq,                             // alu zero flag for beq
    output ctrl_t   ctrl                            // control word for the datapath
);

    always_comb begin
        case (opcode)
            op_r: begin
                ctrl.pc_src     = 1'b0;
                ctrl.result_src = res_alu;          // alu result back to rd
                ctrl.mem_write  = 1'b0;
                ctrl.alu_src    = 1'b0;             // rs2 as operand b
                ctrl.imm_src    = imm_i;            // unused here
                ctrl.reg_write  = 1'b1;
                ctrl.alu_op     = aop_funct;
            end
            op_load: begin
                ctrl.pc_src     = 1'b0;
                ctrl.result_src = res_mem;          // load data back to rd
                ctrl.mem_write  = 1'b0;
                ctrl.alu_src    = 1'b1;             // base plus offset
                ctrl.imm_src    = imm_i;
                ctrl.reg_write  = 1'b1;
                ctrl.alu_op     = aop_add;
            end
            op_imm: begin
                ctrl.pc_src     = 1'b0;
                ctrl.result_src = res_alu;
                ctrl.mem_write  = 1'b0;
                ctrl.alu_src    = 1'b1;
                ctrl.imm_src    = imm_i;
                ctrl.reg_write  = 1'b1;
                ctrl.alu_op     = aop_funct;        // andi, ori and slti need funct3
            end
            op_store: begin
                ctrl.pc_src     = 1'b0;
                ctrl.result_src = res_alu;          // don't care, no write-back
                ctrl.mem_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.imm_src    = imm_s;
                ctrl.reg_write  = 1'b0;
                ctrl.alu_op     = aop_add;
            end
            op_branch: begin
                ctrl.pc_src     = eq;               // taken only on equal
                ctrl.result_src = res_alu;
                ctrl.mem_write  = 1'b0;
                ctrl.alu_src    = 1'b0;             // compare rs1 with rs2
                ctrl.imm_src    = imm_b;
                ctrl.reg_write  = 1'b0;
                ctrl.alu_op     = aop_sub;
            end
            op_jal: begin
                ctrl.pc_src     = 1'b1;             // unconditional
                ctrl.result_src = res_pc4;          // link address
                ctrl.mem_write  = 1'b0;
                ctrl.alu_src    = 1'b1;
                ctrl.imm_src    = imm_j;
                ctrl.reg_write  = 1'b1;
                ctrl.alu_op     = aop_add;          // alu result not used
            end
            default: begin
                ctrl = ctrl_nop;                    // illegal word behaves as a nop
            end
        endcase
    end

endmodule

// ==== rtl/alu_decoder.sv ====
module alu_decoder import rv_pkg::*; (
    input  alu_op_e    alu_op,                      // class from the main decoder
    input  logic [2:0] funct3,
    input  logic       funct7_b5,                   // instruction bit 30
    input  logic       op_b5,                       // opcode bit 5, set for r-type
    output alu_ctrl_e  alu_ctrl
);

    logic is_sub;                                   // r-type sub only

    // addi has no funct7, its bit 30 belongs to the immediate
    assign is_sub = funct7_b5 && op_b5;

    always_comb begin
        case (alu_op)
            aop_add: alu_ctrl = alu_add;            // lw, sw, jal
            aop_sub: alu_ctrl = alu_sub;            // beq
            aop_funct: begin
                case (funct3)
                    f3_add:  alu_ctrl = is_sub ? alu_sub : alu_add;
                    f3_slt:  alu_ctrl = alu_slt;
                    f3_or:   alu_ctrl = alu_or;
                    f3_and:  alu_ctrl = alu_and;
                    default: alu_ctrl = alu_add;    // outside the subset
                endcase
            end
            default: begin
                alu_ctrl = alu_add;
            end
        endcase
    end

endmodule

// ==== rtl/reg_file.sv ====
module reg_file import rv_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    input  logic [4:0]      rd_addr,
    input  logic [xlen-1:0] rd_data,                // write-back value
    input  logic            we,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data
);

    logic [xlen-1:0] regs [1:reg_count-1];          // x0 has no storage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 1; k < reg_count; k++) begin
                regs[k] <= '0;
            end
        end else if (we && (rd_addr != 5'd0)) begin
            regs[rd_addr] <= rd_data;               // writes to x0 dropped
        end
    end

    // combinational read, new value seen only after the edge
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== rtl/imm_extend.sv ====
module imm_extend import rv_pkg::*; (
    input  instr_t          instr,                  // raw instruction word
    input  imm_src_e        imm_src,                // which format to read
    output logic [xlen-1:0] imm                     // sign-extended immediate
);

    always_comb begin
        case (imm_src)
            imm_i: imm = {{(xlen-12){instr.i.imm[11]}}, instr.i.imm};
            imm_s: imm = {{(xlen-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            imm_b: begin                            // bit 0 always zero
                imm = {{(xlen-12){instr.b.imm_12}}, instr.b.imm_11,
                       instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            end
            imm_j: begin                            // 21-bit offset, halfword granular
                imm = {{(xlen-20){instr.j.imm_20}}, instr.j.imm_19_12,
                       instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// ==== rtl/alu.sv ====
module alu import rv_pkg::*; (
    input  logic [xlen-1:0] a,                      // rs1
    input  logic [xlen-1:0] b,                      // rs2 or immediate
    input  alu_ctrl_e       alu_ctrl,
    output logic [xlen-1:0] result,
    output logic            zero                    // eq for beq
);

    logic lt;                                       // signed a < b

    assign lt = $signed(a) < $signed(b);

    always_comb begin
        case (alu_ctrl)
            alu_add: result = a + b;
            alu_sub: result = a - b;                // also the beq compare
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_slt: result = {{(xlen-1){1'b0}}, lt};
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== rtl/rv_core.sv ====
module rv_core import rv_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    output logic [xlen-1:0] imem_addr,              // fetch address, the pc
    input  instr_t          imem_rdata,             // instruction read in the same cycle
    output dmem_req_t       dmem_req,               // data port request
    input  logic [xlen-1:0] dmem_rdata              // load data, same cycle
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;                      // fall-through and link address
    logic [xlen-1:0] pc_target;                     // branch and jal target
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] src_b;                         // second alu operand
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] result;                        // write-back value
    logic            zero;
    ctrl_t           ctrl;
    alu_ctrl_e       alu_ctrl;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_vec;
        end else begin
            pc <= ctrl.pc_src ? pc_target : pc_plus4;   // one instruction per edge
        end
    end

    assign pc_plus4  = pc + instr_bytes;
    assign pc_target = pc + imm;                    // pc relative for beq and jal
    assign imem_addr = pc;

    assign src_b = ctrl.alu_src ? imm : rs2_data;

    always_comb begin
        case (ctrl.result_src)
            res_alu: result = alu_result;
            res_mem: result = dmem_rdata;
            res_pc4: result = pc_plus4;             // jal link
            default: result = alu_result;
        endcase
    end

    assign dmem_req.we    = ctrl.mem_write;
    assign dmem_req.addr  = alu_result;             // rs1 plus offset
    assign dmem_req.wdata = rs2_data;

    main_decoder i_main_decoder (
        .opcode (imem_rdata.r.opcode),
        .eq     (zero),
        .ctrl   (ctrl)
    );

    alu_decoder i_alu_decoder (
        .alu_op    (ctrl.alu_op),
        .funct3    (imem_rdata.r.funct3),
        .funct7_b5 (imem_rdata.r.funct7[5]),
        .op_b5     (imem_rdata.r.opcode[5]),
        .alu_ctrl  (alu_ctrl)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (imem_rdata.r.rs1),
        .rs2_addr (imem_rdata.r.rs2),
        .rd_addr  (imem_rdata.r.rd),
        .rd_data  (result),
        .we       (ctrl.reg_write),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    imm_extend i_imm_extend (
        .instr   (imem_rdata),
        .imm_src (ctrl.imm_src),
        .imm     (imm)
    );

    alu i_alu (
        .a        (rs1_data),
        .b        (src_b),
        .alu_ctrl (alu_ctrl),
        .result   (alu_result),
        .zero     (zero)
    );

endmodule

// ==== tests/rv_core_chk.sv ====
module rv_core_chk import rv_pkg::*; (
    input logic            clk,
    input logic            arst_n,
    input logic [xlen-1:0] pc,
    input dmem_req_t       dmem_req,
    input logic [4:0]      rs1_addr,
    input logic [4:0]      rs2_addr,
    input logic [xlen-1:0] rs1_data,
    input logic [xlen-1:0] rs2_data
);

    int fail_count = 0;                                 // summed into the final count

    pc_in_reset: assert property (@(posedge clk) !arst_n |-> pc == '0)
        else begin
            $error("pc not at the reset vector while reset is held");
            fail_count++;
        end

    pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
        else begin
            $error("pc is not word aligned");
            fail_count++;
        end

    we_known: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(dmem_req.we))
        else begin
            $error("data write enable is unknown");
            fail_count++;
        end

    st_aligned: assert property (@(posedge clk) disable iff (!arst_n)
                                 dmem_req.we |-> dmem_req.addr[1:0] == 2'b00)
        else begin
            $error("store address is not word aligned");
            fail_count++;
        end

    // x0 reads zero on both ports
    x0_zero: assert property (@(posedge clk) disable iff (!arst_n)
                              (rs1_addr != 5'd0 || rs1_data == '0) &&
                              (rs2_addr != 5'd0 || rs2_data == '0))
        else begin
            $error("read of x0 returned a nonzero value");
            fail_count++;
        end

endmodule

bind rv_core rv_core_chk i_chk (
    .clk      (clk),
    .arst_n   (arst_n),
    .pc       (pc),
    .dmem_req (dmem_req),
    .rs1_addr (imem_rdata.r.rs1),
    .rs2_addr (imem_rdata.r.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
);

// ==== tests/rv_core_tb.sv ====
module rv_core_tb import rv_pkg::*; ();

    localparam int run_len  = 40;                       // cycles each program runs
    localparam int rst_len  = 4;                        // reset held for this many cycles
    localparam int wd_limit = 6 * (run_len + rst_len + 2) * 10 * 2;    // six tests, margin 2

    logic            clk;
    logic            arst_n;
    logic [xlen-1:0] imem_addr;
    instr_t          imem_rdata;
    dmem_req_t       dmem_req;
    logic [xlen-1:0] dmem_rdata;

    logic [31:0] imem [0:63];                           // program memory, 64 words
    logic [31:0] dmem [0:255];                          // data memory, 1 KiB
    logic [31:0] st_addr [$];                           // stores seen on the data bus
    logic [31:0] st_data [$];
    logic [31:0] exp_addr [$];                          // stores the program should make
    logic [31:0] exp_data [$];
    int          prog_len;
    int          errors, test_errs, tests_run, tests_bad;

    rv_core i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    assign imem_rdata = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_req.addr[9:2]];

    always @(posedge clk) begin
        if (arst_n && dmem_req.we) begin
            dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
            st_addr.push_back(dmem_req.addr);
            st_data.push_back(dmem_req.wdata);
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(wd_limit);
        $display("watchdog timeout, the tests did not finish in time");
        $display("tests failed");
        $finish;
    end

    // hand encoders, field layout from the base ISA
    function automatic logic [31:0] enc_r(input logic sub, input logic [2:0] f3,
                                          input int rd, rs1, rs2);
        return {1'b0, sub, 5'd0, rs2[4:0], rs1[4:0], f3, rd[4:0], op_r};
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input int rd, rs1, imm,
                                          input opcode_e op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_s(input int src, base, imm);    // sw src, imm(base)
        return {imm[11:5], src[4:0], base[4:0], 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] enc_b(input int rs1, rs2, imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_j(input int rd, imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], op_jal};
    endfunction

    // two's complement order from the sign bits and the magnitude
    function automatic logic [31:0] signed_less(input logic [31:0] x, input logic [31:0] y);
        if (x[31] != y[31]) begin
            return {31'd0, x[31]};                      // signs differ, the negative one is less
        end
        return {31'd0, x < y};                          // same sign, plain unsigned order
    endfunction

    function automatic void emit(input logic [31:0] word);
        imem[prog_len[5:0]] = word;
        prog_len++;
    endfunction

    function automatic void expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endfunction

    function automatic void emit_and_store(input logic [31:0] word, input int off,
                                           input logic [31:0] val);
        emit(word);                                     // result lands in x3
        emit(enc_s(3, 0, off));
        expect_store(off, val);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            test_errs++;
        end
    endtask

    task automatic begin_test();
        @(posedge clk);
        arst_n <= 1'b0;
        @(posedge clk);                                 // core held in reset from here
        imem = '{default: '0};                          // zero word decodes as a nop
        dmem <= '{default: '0};
        st_addr.delete();
        st_data.delete();
        exp_addr.delete();
        exp_data.delete();
        prog_len = 0;
        test_errs = 0;
    endtask

    task automatic release_reset(input string name);
        emit(enc_j(0, 0));                              // jal x0, 0 parks the core
        repeat (rst_len - 1) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value(name, 32'd0, imem_addr);            // first fetch from address 0
    endtask

    task automatic run(input int cycles);
        repeat (cycles) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic compare_stores(input string name);
        if (st_addr.size() != exp_addr.size()) begin
            $display("%s: expected %0d stores on the data bus but saw %0d", name,
                     exp_addr.size(), st_addr.size());
            test_errs++;
        end
        for (int k = 0; k < st_addr.size() && k < exp_addr.size(); k++) begin
            check_value(name, exp_addr[k], st_addr[k]);
            check_value(name, exp_data[k], st_data[k]);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        errors += test_errs;
        if (test_errs == 0) begin
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, test_errs);
        end
    endtask

    task automatic run_and_check(input string name);
        release_reset(name);
        run(run_len);
        compare_stores(name);
        end_test(name);
    endtask

    task automatic test_alu();
        logic [31:0] a;
        logic [31:0] b;
        begin_test();
        a = $urandom() & 32'hfff;
        b = $urandom() & 32'hfff;
        emit(enc_i(f3_add, 1, 0, a, op_imm));           // x1 = a
        emit(enc_i(f3_add, 2, 0, b, op_imm));           // x2 = b
        a = {{20{a[11]}}, a[11:0]};                     // value addi leaves behind
        b = {{20{b[11]}}, b[11:0]};
        emit_and_store(enc_r(1'b0, f3_add, 3, 1, 2), 0, a + b);
        emit_and_store(enc_r(1'b1, f3_add, 3, 1, 2), 4, a - b);
        emit_and_store(enc_r(1'b0, f3_and, 3, 1, 2), 8, a & b);
        emit_and_store(enc_r(1'b0, f3_or, 3, 1, 2), 12, a | b);
        emit_and_store(enc_r(1'b0, f3_slt, 3, 1, 2), 16, signed_less(a, b));
        emit_and_store(enc_i(f3_add, 3, 1, b, op_imm), 20, a + b);
        emit_and_store(enc_i(f3_and, 3, 1, b, op_imm), 24, a & b);
        emit_and_store(enc_i(f3_or, 3, 1, b, op_imm), 28, a | b);
        emit_and_store(enc_i(f3_slt, 3, 1, b, op_imm), 32, signed_less(a, b));
        emit_and_store(enc_i(f3_add, 3, 1, -1024, op_imm), 36, a - 32'd1024);  // bit 30 set
        run_and_check("alu");
    endtask

    task automatic test_load_store();
        logic [31:0] v;
        begin_test();
        v = $urandom() & 32'hfff;
        emit(enc_i(f3_add, 5, 0, 512, op_imm));         // base pointer in x5
        emit(enc_i(f3_add, 1, 0, v, op_imm));
        emit(enc_s(1, 5, -8));
        emit(enc_i(3'b010, 2, 5, -8, op_load));         // lw x2, -8(x5)
        emit(enc_i(f3_add, 2, 2, 1, op_imm));
        emit(enc_s(2, 5, -12));
        v = {{20{v[11]}}, v[11:0]};
        expect_store(32'd512 - 32'd8, v);
        expect_store(32'd512 - 32'd12, v + 32'd1);
        run_and_check("load_store");
    endtask

    task automatic test_branch();
        begin_test();
        emit(enc_i(f3_add, 1, 0, 5, op_imm));
        emit(enc_i(f3_add, 2, 0, 5, op_imm));
        emit(enc_i(f3_add, 3, 0, 7, op_imm));
        emit(enc_b(1, 2, 8));                           // equal, skips next word
        emit(enc_s(1, 0, 64));                          // marker that must not show
        emit(enc_s(2, 0, 68));
        emit(enc_b(1, 3, 8));                           // unequal, falls through
        emit(enc_s(3, 0, 72));
        expect_store(68, 5);
        expect_store(72, 7);
        run_and_check("branch");
    endtask

    task automatic test_jal();
        begin_test();
        emit(enc_i(f3_add, 2, 0, 99, op_imm));
        emit(enc_j(1, 8));                              // at address 4, over one word
        emit(enc_s(2, 0, 80));                          // skipped
        emit(enc_s(1, 0, 84));                          // link register
        expect_store(84, 32'd4 + 32'd4);
        run_and_check("jal");
    endtask

    task automatic test_x0();
        begin_test();
        emit(enc_i(f3_add, 0, 0, 123, op_imm));         // write to x0 is dropped
        emit(enc_s(0, 0, 96));
        emit(32'hffff_ffff);                            // unknown opcode
        emit(enc_i(f3_add, 1, 0, 33, op_imm));
        emit(enc_s(1, 0, 100));
        expect_store(96, 0);
        expect_store(100, 33);
        run_and_check("x0");
    endtask

    task automatic test_reset();
        begin_test();
        emit(enc_i(f3_add, 1, 0, 11, op_imm));
        emit(enc_i(f3_add, 2, 1, 1, op_imm));
        emit(32'h0000_0000);
        emit(enc_s(2, 0, 112));                         // first store, fourth word
        expect_store(112, 12);
        release_reset("reset");
        run(3);
        if (st_addr.size() != 0) begin
            $display("reset: a store appeared before the first sw");
            test_errs++;
        end
        run(run_len - 3);
        compare_stores("reset");
        end_test("reset");
    endtask

    initial begin
        void'($urandom(32'h129f_d5aa));
        arst_n = 1'b0;
        imem = '{default: '0};
        dmem <= '{default: '0};
        errors = 0;
        tests_run = 0;
        tests_bad = 0;
        test_alu();
        test_load_store();
        test_branch();
        test_jal();
        test_x0();
        test_reset();
        errors += i_dut.i_chk.fail_count;              // failed assertions of the checker
        $display("summary: %0d tests, %0d with errors, %0d errors", tests_run, tests_bad,
                 errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
rtl/rv_pkg.sv
rtl/main_decoder.sv
rtl/alu_decoder.sv
rtl/reg_file.sv
rtl/imm_extend.sv
rtl/alu.sv
rtl/rv_core.sv
tests/rv_core_chk.sv
tests/rv_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_core_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
ERR_LIMIT ?= 100
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f sources.f
	-./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERR_LIMIT) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "all tests passed" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
